// ==== asic_video_pkg.sv ====
package asic_video_pkg;

    ////////////////////////////////////////////////////////////
    // Counter widths
    ////////////////////////////////////////////////////////////

    localparam int unsigned hc_width = 10;
    localparam int unsigned vc_width = 9;

    ////////////////////////////////////////////////////////////
    // PAL frame geometry
    ////////////////////////////////////////////////////////////

    // Pixel clocks per line and lines per frame
    localparam logic [hc_width-1:0] h_total = 10'd768;
    localparam logic [vc_width-1:0] v_total = 9'd312;

    // Horizontal sync window, in pixels
    localparam logic [hc_width-1:0] h_sync_start = 10'd80;
    localparam logic [hc_width-1:0] h_sync_len   = 10'd64;

    // Vertical sync window, in lines
    localparam logic [vc_width-1:0] v_sync_start = 9'd244;
    localparam logic [vc_width-1:0] v_sync_len   = 9'd4;

    // Interrupts stay low for the first pixels of the line
    localparam logic [hc_width-1:0] int_len = 10'd256;

    // Line interrupt values from here upwards are disabled
    localparam logic [7:0] active_lines = 8'd192;

endpackage

// ==== asic_bus_pkg.sv ====
package asic_bus_pkg;

    ////////////////////////////////////////////////////////////
    // CPU address, decoded per cycle type
    ////////////////////////////////////////////////////////////

    // Memory cycles see a 16K section and an offset,
    // I/O cycles see a high byte and a port number
    typedef union packed {
        struct packed {
            logic [1:0]  section;
            logic [13:0] offset;
        } mem;
        struct packed {
            logic [7:0] high;
            logic [7:0] port;
        } io;
    } cpu_addr_u;

    ////////////////////////////////////////////////////////////
    // I/O port numbers
    ////////////////////////////////////////////////////////////

    localparam logic [7:0] port_vmpr    = 8'd252;
    localparam logic [7:0] port_hmpr    = 8'd251;
    localparam logic [7:0] port_lmpr    = 8'd250;
    localparam logic [7:0] port_border  = 8'd254;
    localparam logic [7:0] port_lineint = 8'd249;
    localparam logic [7:0] port_status  = 8'd249;
    localparam logic [7:0] port_keyrow  = 8'd255;

    // Disk controller windows
    localparam logic [7:0] disc1_lo = 8'd224;
    localparam logic [7:0] disc1_hi = 8'd231;
    localparam logic [7:0] disc2_lo = 8'd240;
    localparam logic [7:0] disc2_hi = 8'd247;

    ////////////////////////////////////////////////////////////
    // Memory map
    ////////////////////////////////////////////////////////////

    localparam int unsigned page_width     = 5;
    localparam int unsigned ram_addr_width = 19;

    // 16K sections of the CPU address space
    localparam logic [1:0] sec_a = 2'd0;
    localparam logic [1:0] sec_b = 2'd1;
    localparam logic [1:0] sec_c = 2'd2;
    localparam logic [1:0] sec_d = 2'd3;

    ////////////////////////////////////////////////////////////
    // Register bit positions
    ////////////////////////////////////////////////////////////

    localparam int unsigned lmpr_rom_a_off = 5;
    localparam int unsigned lmpr_rom_d_on  = 6;
    localparam int unsigned lmpr_wprot     = 7;
    localparam int unsigned hmpr_ext_mem   = 7;
    localparam int unsigned border_mic     = 3;
    localparam int unsigned border_beep    = 4;
    localparam int unsigned border_scr_off = 7;
    localparam int unsigned vmpr_mode_hi   = 6;

    // Line interrupt off after reset
    localparam logic [7:0] lineint_reset = 8'hFF;

endpackage

// ==== io_port_regs.sv ====
module io_port_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    iorq_n,
    input  logic                    wr_n,
    input  asic_bus_pkg::cpu_addr_u cpu_addr,
    input  logic [7:0]              data_from_cpu,
    output logic [7:0]              vmpr,
    output logic [7:0]              lmpr,
    output logic [7:0]              hmpr,
    output logic [7:0]              border,
    output logic [7:0]              lineint,
    output logic                    mic,
    output logic                    beep
);

    logic       io_write;
    logic [7:0] port;

    assign io_write = !iorq_n && !wr_n;
    assign port     = cpu_addr.io.port;

    ////////////////////////////////////////////////////////////
    // Register file
    ////////////////////////////////////////////////////////////

    // No wait states, so a write always lands in its own cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vmpr    <= 8'h00;
            lmpr    <= 8'h00;
            hmpr    <= 8'h00;
            border  <= 8'h00;
            lineint <= asic_bus_pkg::lineint_reset;
        end else if (io_write) begin
            case (port)
                asic_bus_pkg::port_vmpr: begin
                    vmpr <= data_from_cpu;
                end
                asic_bus_pkg::port_lmpr: begin
                    lmpr <= data_from_cpu;
                end
                asic_bus_pkg::port_hmpr: begin
                    hmpr <= data_from_cpu;
                end
                asic_bus_pkg::port_border: begin
                    border <= data_from_cpu;
                end
                asic_bus_pkg::port_lineint: begin
                    lineint <= data_from_cpu;
                end
                default: begin
                end
            endcase
        end
    end

    // Audio outputs straight from the border register
    assign mic  = border[asic_bus_pkg::border_mic];
    assign beep = border[asic_bus_pkg::border_beep];

endmodule

// ==== raster_timing.sv ====
module raster_timing (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] lineint,
    output logic       hsync_pal,
    output logic       vsync_pal,
    output logic       vint_n,
    output logic       rint_n,
    output logic       int_n
);

    logic [asic_video_pkg::hc_width-1:0] hc;
    logic [asic_video_pkg::vc_width-1:0] vc;
    logic                                line_end;
    logic                                frame_end;
    logic                                hsync_win;
    logic                                vsync_win;
    logic                                int_win;
    logic                                rint_en;

    ////////////////////////////////////////////////////////////
    // Pixel and line counters
    ////////////////////////////////////////////////////////////

    assign line_end  = hc == asic_video_pkg::h_total - 1'b1;
    assign frame_end = vc == asic_video_pkg::v_total - 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hc <= '0;
            vc <= '0;
        end else if (line_end) begin
            hc <= '0;
            if (frame_end) begin
                vc <= '0;
            end else begin
                vc <= vc + 1'b1;
            end
        end else begin
            hc <= hc + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Sync windows
    ////////////////////////////////////////////////////////////

    assign hsync_win = hc >= asic_video_pkg::h_sync_start &&
                       hc < asic_video_pkg::h_sync_start + asic_video_pkg::h_sync_len;

    // Vertical sync spans whole lines from pixel 0
    assign vsync_win = vc >= asic_video_pkg::v_sync_start &&
                       vc < asic_video_pkg::v_sync_start + asic_video_pkg::v_sync_len;

    assign hsync_pal = !hsync_win;
    assign vsync_pal = !vsync_win;

    ////////////////////////////////////////////////////////////
    // Frame and line interrupts
    ////////////////////////////////////////////////////////////

    // Both interrupts share the same window at the start of a line
    assign int_win = hc < asic_video_pkg::int_len;

    // Frame interrupt starts together with vertical sync
    assign vint_n = !(int_win && vc == asic_video_pkg::v_sync_start);

    // Line values past the active screen switch it off
    assign rint_en = lineint < asic_video_pkg::active_lines;
    assign rint_n  = !(int_win && rint_en && vc == {1'b0, lineint});

    assign int_n = vint_n && rint_n;

endmodule

// ==== cpu_memory_map.sv ====
module cpu_memory_map (
    input  logic                                    mreq_n,
    input  logic                                    wr_n,
    input  asic_bus_pkg::cpu_addr_u                 cpu_addr,
    input  logic [7:0]                              lmpr,
    input  logic [7:0]                              hmpr,
    output logic                                    romcs_n,
    output logic                                    ramcs_n,
    output logic                                    ramwr_n,
    output logic [asic_bus_pkg::ram_addr_width-1:0] cpuramaddr
);

    logic [1:0]                          section;
    logic [asic_bus_pkg::page_width-1:0] low_page;
    logic [asic_bus_pkg::page_width-1:0] high_page;
    logic [asic_bus_pkg::page_width-1:0] page;
    logic                                rom_hit;
    logic                                ext_hit;
    logic                                wprot_hit;

    assign section   = cpu_addr.mem.section;
    assign low_page  = lmpr[asic_bus_pkg::page_width-1:0];
    assign high_page = hmpr[asic_bus_pkg::page_width-1:0];

    ////////////////////////////////////////////////////////////
    // ROM and RAM selects
    ////////////////////////////////////////////////////////////

    // ROM in A unless switched off, in D only when switched on
    assign rom_hit = (section == asic_bus_pkg::sec_a && !lmpr[asic_bus_pkg::lmpr_rom_a_off]) ||
                     (section == asic_bus_pkg::sec_d && lmpr[asic_bus_pkg::lmpr_rom_d_on]);

    // External memory takes over the upper 32K
    assign ext_hit = hmpr[asic_bus_pkg::hmpr_ext_mem] && section[1];

    assign romcs_n = !(!mreq_n && rom_hit);
    assign ramcs_n = !(!mreq_n && !rom_hit && !ext_hit);

    ////////////////////////////////////////////////////////////
    // RAM page and write strobe
    ////////////////////////////////////////////////////////////

    // Second page of each pair wraps within 5 bits
    always_comb begin
        case (section)
            asic_bus_pkg::sec_a: page = low_page;
            asic_bus_pkg::sec_b: page = low_page + 1'b1;
            asic_bus_pkg::sec_c: page = high_page;
            default:             page = high_page + 1'b1;
        endcase
    end

    assign cpuramaddr = {page, cpu_addr.mem.offset};

    assign wprot_hit = section == asic_bus_pkg::sec_a && lmpr[asic_bus_pkg::lmpr_wprot];
    assign ramwr_n   = !(!ramcs_n && !wr_n && !wprot_hit);

endmodule

// ==== cpu_read_mux.sv ====
module cpu_read_mux (
    input  logic                    iorq_n,
    input  logic                    rd_n,
    input  asic_bus_pkg::cpu_addr_u cpu_addr,
    input  logic                    ear,
    input  logic [7:0]              keyboard,
    input  logic [7:0]              vmpr,
    input  logic [7:0]              lmpr,
    input  logic [7:0]              hmpr,
    input  logic [7:0]              border,
    input  logic                    vint_n,
    input  logic                    rint_n,
    output logic [7:0]              data_to_cpu,
    output logic                    data_enable_n,
    output logic                    disc1_n,
    output logic                    disc2_n,
    output logic                    rdmsel
);

    logic       io_read;
    logic       screen_off;
    logic [7:0] port;

    assign io_read    = !iorq_n && !rd_n;
    assign port       = cpu_addr.io.port;
    assign screen_off = border[asic_bus_pkg::border_scr_off] &&
                        vmpr[asic_bus_pkg::vmpr_mode_hi];

    ////////////////////////////////////////////////////////////
    // Port read decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        data_to_cpu   = 8'hFF;
        data_enable_n = 1'b1;
        disc1_n       = 1'b1;
        disc2_n       = 1'b1;
        if (io_read) begin
            data_enable_n = 1'b0;
            if (port == asic_bus_pkg::port_border) begin
                data_to_cpu = {screen_off, ear, 1'b0, keyboard[4:0]};
            end else if (port == asic_bus_pkg::port_status) begin
                // Interrupt flags read low while active
                data_to_cpu = {keyboard[7:5], 1'b1, vint_n, 2'b11, rint_n};
            end else if (port == asic_bus_pkg::port_vmpr) begin
                data_to_cpu = vmpr;
            end else if (port == asic_bus_pkg::port_hmpr) begin
                data_to_cpu = hmpr;
            end else if (port == asic_bus_pkg::port_lmpr) begin
                data_to_cpu = lmpr;
            end else if (port inside {[asic_bus_pkg::disc1_lo:asic_bus_pkg::disc1_hi]}) begin
                // Disk controller drives the bus itself
                disc1_n       = 1'b0;
                data_enable_n = 1'b1;
            end else if (port inside {[asic_bus_pkg::disc2_lo:asic_bus_pkg::disc2_hi]}) begin
                disc2_n       = 1'b0;
                data_enable_n = 1'b1;
            end else begin
                data_enable_n = 1'b1;
            end
        end
        // Bus floats high when nothing is enabled
        if (data_enable_n) begin
            data_to_cpu = 8'hFF;
        end
    end

    // Keyboard row select on high byte FF
    assign rdmsel = cpu_addr.io.high != asic_bus_pkg::port_keyrow;

endmodule

// ==== asic_top.sv ====
module asic_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mreq_n,
    input  logic        iorq_n,
    input  logic        rd_n,
    input  logic        wr_n,
    input  logic [15:0] cpuaddr,
    input  logic [7:0]  data_from_cpu,
    output logic [7:0]  data_to_cpu,
    output logic        data_enable_n,
    output logic [18:0] cpuramaddr,
    output logic        ramwr_n,
    output logic        romcs_n,
    output logic        ramcs_n,
    input  logic        ear,
    output logic        mic,
    output logic        beep,
    input  logic [7:0]  keyboard,
    output logic        rdmsel,
    output logic        disc1_n,
    output logic        disc2_n,
    output logic        hsync_pal,
    output logic        vsync_pal,
    output logic        int_n
);

    asic_bus_pkg::cpu_addr_u cpu_addr;

    logic [7:0] vmpr;
    logic [7:0] lmpr;
    logic [7:0] hmpr;
    logic [7:0] border;
    logic [7:0] lineint;
    logic       vint_n;
    logic       rint_n;

    // Same bus seen as memory address or port number
    assign cpu_addr = cpuaddr;

    ////////////////////////////////////////////////////////////
    // Control registers
    ////////////////////////////////////////////////////////////

    io_port_regs u_io_port_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .iorq_n        (iorq_n),
        .wr_n          (wr_n),
        .cpu_addr      (cpu_addr),
        .data_from_cpu (data_from_cpu),
        .vmpr          (vmpr),
        .lmpr          (lmpr),
        .hmpr          (hmpr),
        .border        (border),
        .lineint       (lineint),
        .mic           (mic),
        .beep          (beep)
    );

    ////////////////////////////////////////////////////////////
    // Raster, syncs and interrupts
    ////////////////////////////////////////////////////////////

    raster_timing u_raster_timing (
        .clk       (clk),
        .rst_n     (rst_n),
        .lineint   (lineint),
        .hsync_pal (hsync_pal),
        .vsync_pal (vsync_pal),
        .vint_n    (vint_n),
        .rint_n    (rint_n),
        .int_n     (int_n)
    );

    ////////////////////////////////////////////////////////////
    // CPU memory and read-back
    ////////////////////////////////////////////////////////////

    cpu_memory_map u_cpu_memory_map (
        .mreq_n     (mreq_n),
        .wr_n       (wr_n),
        .cpu_addr   (cpu_addr),
        .lmpr       (lmpr),
        .hmpr       (hmpr),
        .romcs_n    (romcs_n),
        .ramcs_n    (ramcs_n),
        .ramwr_n    (ramwr_n),
        .cpuramaddr (cpuramaddr)
    );

    cpu_read_mux u_cpu_read_mux (
        .iorq_n        (iorq_n),
        .rd_n          (rd_n),
        .cpu_addr      (cpu_addr),
        .ear           (ear),
        .keyboard      (keyboard),
        .vmpr          (vmpr),
        .lmpr          (lmpr),
        .hmpr          (hmpr),
        .border        (border),
        .vint_n        (vint_n),
        .rint_n        (rint_n),
        .data_to_cpu   (data_to_cpu),
        .data_enable_n (data_enable_n),
        .disc1_n       (disc1_n),
        .disc2_n       (disc2_n),
        .rdmsel        (rdmsel)
    );

endmodule

// ==== asic_properties.sv ====
module asic_properties (
    input logic        clk,
    input logic        rst_n,
    input logic        mreq_n,
    input logic        iorq_n,
    input logic        rd_n,
    input logic        wr_n,
    input logic [15:0] cpuaddr,
    input logic [7:0]  data_from_cpu,
    input logic [7:0]  data_to_cpu,
    input logic        data_enable_n,
    input logic [18:0] cpuramaddr,
    input logic        ramwr_n,
    input logic        romcs_n,
    input logic        ramcs_n,
    input logic        ear,
    input logic        mic,
    input logic        beep,
    input logic [7:0]  keyboard,
    input logic        rdmsel,
    input logic        disc1_n,
    input logic        disc2_n,
    input logic        hsync_pal,
    input logic        vsync_pal,
    input logic        int_n
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // Copies of the control registers, built from observed writes
    logic [7:0] sh_vmpr;
    logic [7:0] sh_lmpr;
    logic [7:0] sh_hmpr;
    logic [7:0] sh_border;
    logic [7:0] sh_lineint;

    // Sync observation
    int   hs_low;
    int   hs_period;
    int   vs_low;
    int   vs_period;
    logic hs_seen;
    logic vs_seen;
    logic prev_hs;
    logic prev_vs;

    logic        io_wr;
    logic        io_rd;
    logic [7:0]  port;
    logic [1:0]  section;
    logic [4:0]  page;
    logic        rom_sel;
    logic        ext_sel;
    logic        exp_romcs_n;
    logic        exp_ramcs_n;
    logic        exp_ramwr_n;
    logic [18:0] exp_ramaddr;
    logic        exp_den;
    logic [1:0]  exp_disc_n;
    logic        exp_rdmsel;
    logic [7:0]  exp_data;
    logic        vint_win;
    logic        rint_win;
    int          rint_start;

    ////////////////////////////////////////////////////////////
    // Shadow registers and sync counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sh_vmpr    <= 8'h00;
            sh_lmpr    <= 8'h00;
            sh_hmpr    <= 8'h00;
            sh_border  <= 8'h00;
            sh_lineint <= asic_bus_pkg::lineint_reset;
        end else if (io_wr) begin
            case (port)
                asic_bus_pkg::port_vmpr:    sh_vmpr    <= data_from_cpu;
                asic_bus_pkg::port_lmpr:    sh_lmpr    <= data_from_cpu;
                asic_bus_pkg::port_hmpr:    sh_hmpr    <= data_from_cpu;
                asic_bus_pkg::port_border:  sh_border  <= data_from_cpu;
                asic_bus_pkg::port_lineint: sh_lineint <= data_from_cpu;
                default: begin
                end
            endcase
        end
    end

    // Low-time and fall-to-fall counts of both syncs
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hs_low    <= 0;
            hs_period <= 0;
            vs_low    <= 0;
            vs_period <= 0;
            hs_seen   <= 1'b0;
            vs_seen   <= 1'b0;
            prev_hs   <= 1'b1;
            prev_vs   <= 1'b1;
        end else begin
            prev_hs <= hsync_pal;
            prev_vs <= vsync_pal;
            hs_low  <= hsync_pal ? 0 : hs_low + 1;
            vs_low  <= vsync_pal ? 0 : vs_low + 1;
            if (prev_hs && !hsync_pal) begin
                hs_period <= 1;
                hs_seen   <= 1'b1;
            end else begin
                hs_period <= hs_period + 1;
            end
            if (prev_vs && !vsync_pal) begin
                vs_period <= 1;
                vs_seen   <= 1'b1;
            end else begin
                vs_period <= vs_period + 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Expected outputs
    ////////////////////////////////////////////////////////////

    always_comb begin
        io_wr   = !iorq_n && !wr_n;
        io_rd   = !iorq_n && !rd_n;
        port    = cpuaddr[7:0];
        section = cpuaddr[15:14];

        // Frame interrupt for 256 cycles from the vsync fall
        vint_win = !vsync_pal && vs_low < 256;
        // Line L starts (L + 68) lines after the vsync fall
        rint_start = (int'(sh_lineint) + 68) * 768;
        rint_win   = vs_seen && sh_lineint < 8'd192 &&
                     vs_period >= rint_start && vs_period < rint_start + 256;

        rom_sel = (section == 2'd0 && !sh_lmpr[asic_bus_pkg::lmpr_rom_a_off]) ||
                  (section == 2'd3 && sh_lmpr[asic_bus_pkg::lmpr_rom_d_on]);
        ext_sel = sh_hmpr[asic_bus_pkg::hmpr_ext_mem] && section >= 2'd2;
        case (section)
            2'd0:    page = sh_lmpr[4:0];
            2'd1:    page = sh_lmpr[4:0] + 5'd1;
            2'd2:    page = sh_hmpr[4:0];
            default: page = sh_hmpr[4:0] + 5'd1;
        endcase
        exp_romcs_n = mreq_n || !rom_sel;
        exp_ramcs_n = mreq_n || rom_sel || ext_sel;
        exp_ramwr_n = exp_ramcs_n || wr_n ||
                      (section == 2'd0 && sh_lmpr[asic_bus_pkg::lmpr_wprot]);
        exp_ramaddr = {page, cpuaddr[13:0]};

        exp_disc_n[1] = !(io_rd && port >= 8'd224 && port <= 8'd231);
        exp_disc_n[0] = !(io_rd && port >= 8'd240 && port <= 8'd247);
        exp_rdmsel    = cpuaddr[15:8] != 8'hFF;

        exp_data = 8'hFF;
        exp_den  = 1'b1;
        if (io_rd) begin
            exp_den = 1'b0;
            case (port)
                asic_bus_pkg::port_border: begin
                    exp_data = {sh_border[7] && sh_vmpr[6], ear, 1'b0, keyboard[4:0]};
                end
                asic_bus_pkg::port_status: begin
                    exp_data = {keyboard[7:5], 1'b1, !vint_win, 2'b11, !rint_win};
                end
                asic_bus_pkg::port_lmpr: exp_data = sh_lmpr;
                asic_bus_pkg::port_hmpr: exp_data = sh_hmpr;
                asic_bus_pkg::port_vmpr: exp_data = sh_vmpr;
                default:                 exp_den  = 1'b1;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Read path and audio
    ////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (!rst_n) data_to_cpu == exp_data)
        else begin
            $error("ERROR %0t data_to_cpu got %h expected %h", $time,
                   $sampled(data_to_cpu), $sampled(exp_data));
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) data_enable_n == exp_den)
        else begin
            $error("ERROR %0t data_enable_n got %b expected %b", $time,
                   $sampled(data_enable_n), $sampled(exp_den));
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) {disc1_n, disc2_n} == exp_disc_n)
        else begin
            $error("ERROR %0t disc1_n/disc2_n got %b expected %b", $time,
                   $sampled({disc1_n, disc2_n}), $sampled(exp_disc_n));
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) rdmsel == exp_rdmsel)
        else begin
            $error("ERROR %0t rdmsel got %b expected %b", $time,
                   $sampled(rdmsel), $sampled(exp_rdmsel));
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
                     {mic, beep} == {sh_border[asic_bus_pkg::border_mic],
                                     sh_border[asic_bus_pkg::border_beep]})
        else begin
            $error("ERROR %0t mic/beep got %b expected %b", $time, $sampled({mic, beep}),
                   $sampled({sh_border[3], sh_border[4]}));
            fail_count++;
        end

    ////////////////////////////////////////////////////////////
    // Memory paging
    ////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (!rst_n) romcs_n == exp_romcs_n)
        else begin
            $error("ERROR %0t romcs_n got %b expected %b", $time,
                   $sampled(romcs_n), $sampled(exp_romcs_n));
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) ramcs_n == exp_ramcs_n)
        else begin
            $error("ERROR %0t ramcs_n got %b expected %b", $time,
                   $sampled(ramcs_n), $sampled(exp_ramcs_n));
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) ramwr_n == exp_ramwr_n)
        else begin
            $error("ERROR %0t ramwr_n got %b expected %b", $time,
                   $sampled(ramwr_n), $sampled(exp_ramwr_n));
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
                     !exp_ramcs_n |-> cpuramaddr == exp_ramaddr)
        else begin
            $error("ERROR %0t cpuramaddr got %h expected %h", $time,
                   $sampled(cpuramaddr), $sampled(exp_ramaddr));
            fail_count++;
        end

    ////////////////////////////////////////////////////////////
    // Syncs and interrupts
    ////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (!rst_n) $rose(hsync_pal) |-> hs_low == 64)
        else begin
            $error("ERROR %0t hsync_pal low for %0d cycles, expected 64", $time,
                   $sampled(hs_low));
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
                     $fell(hsync_pal) && hs_seen |-> hs_period == 768)
        else begin
            $error("ERROR %0t hsync_pal period %0d cycles, expected 768", $time,
                   $sampled(hs_period));
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) $rose(vsync_pal) |-> vs_low == 3072)
        else begin
            $error("ERROR %0t vsync_pal low for %0d cycles, expected 3072", $time,
                   $sampled(vs_low));
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
                     $fell(vsync_pal) && vs_seen |-> vs_period == 239616)
        else begin
            $error("ERROR %0t vsync_pal period %0d cycles, expected 239616", $time,
                   $sampled(vs_period));
            fail_count++;
        end

    // Covers the frame pulse, the line pulse and silence in between
    assert property (@(posedge clk) disable iff (!rst_n) int_n == !(vint_win || rint_win))
        else begin
            $error("ERROR %0t int_n got %b expected %b", $time,
                   $sampled(int_n), $sampled(!(vint_win || rint_win)));
            fail_count++;
        end

endmodule

bind asic_top asic_properties props (.*);

// ==== tb_asic.sv ====
module tb_asic;
    timeunit 1ns;
    timeprecision 1ps;

    // Two frames plus margin for the register and memory phases
    localparam int max_cycles = 600000;

    logic        clk;
    logic        rst_n;
    logic        mreq_n;
    logic        iorq_n;
    logic        rd_n;
    logic        wr_n;
    logic [15:0] cpuaddr;
    logic [7:0]  data_from_cpu;
    logic [7:0]  data_to_cpu;
    logic        data_enable_n;
    logic [18:0] cpuramaddr;
    logic        ramwr_n;
    logic        romcs_n;
    logic        ramcs_n;
    logic        ear;
    logic        mic;
    logic        beep;
    logic [7:0]  keyboard;
    logic        rdmsel;
    logic        disc1_n;
    logic        disc2_n;
    logic        hsync_pal;
    logic        vsync_pal;
    logic        int_n;

    int cycle_count = 0;

    asic_top dut (.*);

    ////////////////////////////////////////////////////////////
    // Clock, timeout and closing report
    ////////////////////////////////////////////////////////////

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic finish_run(input int timeouts);
        int failures;
        failures = dut.props.fail_count;
        $display("Errors: %0d assertion failures, %0d timeouts", failures, timeouts);
        if (failures == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: stimulus still running after %0d cycles", cycle_count);
            finish_run(1);
        end
    end

    ////////////////////////////////////////////////////////////
    // CPU bus cycles driven 1 ns after the edge
    ////////////////////////////////////////////////////////////

    // High byte is FF often enough to hit the keyboard row select
    function automatic logic [7:0] random_high();
        if ($urandom % 4 == 0) begin
            return 8'hFF;
        end
        return 8'($urandom);
    endfunction

    task automatic bus_idle();
        @(posedge clk);
        #1;
        mreq_n = 1'b1;
        iorq_n = 1'b1;
        rd_n   = 1'b1;
        wr_n   = 1'b1;
    endtask

    task automatic io_write(input logic [7:0] port, input logic [7:0] data);
        @(posedge clk);
        #1;
        mreq_n        = 1'b1;
        iorq_n        = 1'b0;
        rd_n          = 1'b1;
        wr_n          = 1'b0;
        cpuaddr       = {random_high(), port};
        data_from_cpu = data;
    endtask

    task automatic io_read(input logic [7:0] port);
        @(posedge clk);
        #1;
        mreq_n   = 1'b1;
        iorq_n   = 1'b0;
        rd_n     = 1'b0;
        wr_n     = 1'b1;
        cpuaddr  = {random_high(), port};
        ear      = 1'($urandom);
        keyboard = 8'($urandom);
    endtask

    task automatic mem_cycle();
        logic is_write;
        is_write = 1'($urandom);
        @(posedge clk);
        #1;
        mreq_n        = 1'b0;
        iorq_n        = 1'b1;
        rd_n          = is_write;
        wr_n          = !is_write;
        cpuaddr       = 16'($urandom);
        data_from_cpu = 8'($urandom);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        int line;
        void'($urandom(90));
        rst_n         = 1'b0;
        mreq_n        = 1'b1;
        iorq_n        = 1'b1;
        rd_n          = 1'b1;
        wr_n          = 1'b1;
        cpuaddr       = 16'h0000;
        data_from_cpu = 8'h00;
        ear           = 1'b0;
        keyboard      = 8'hFF;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Register writes and read-back
        repeat (8) begin
            io_write(asic_bus_pkg::port_lmpr, 8'($urandom));
            io_write(asic_bus_pkg::port_hmpr, 8'($urandom));
            io_write(asic_bus_pkg::port_vmpr, 8'($urandom));
            io_write(asic_bus_pkg::port_border, 8'($urandom));
            io_read(asic_bus_pkg::port_lmpr);
            io_read(asic_bus_pkg::port_hmpr);
            io_read(asic_bus_pkg::port_vmpr);
            io_read(asic_bus_pkg::port_border);
            io_read(asic_bus_pkg::port_status);
        end

        // Every port number, disk windows and unmapped ports included
        for (int p = 0; p < 256; p++) begin
            io_read(8'(p));
        end

        // Memory cycles with fresh paging every 20 cycles
        for (int i = 0; i < 200; i++) begin
            if (i % 20 == 0) begin
                io_write(asic_bus_pkg::port_lmpr, 8'($urandom));
                io_write(asic_bus_pkg::port_hmpr, 8'($urandom));
            end
            mem_cycle();
        end
        bus_idle();

        // Frame interrupt, then a line interrupt in the next frame
        @(negedge vsync_pal);
        repeat (4) io_read(asic_bus_pkg::port_status);
        line = $urandom % 192;
        io_write(asic_bus_pkg::port_lineint, 8'(line));
        bus_idle();
        @(negedge int_n);
        repeat (2) io_read(asic_bus_pkg::port_status);

        // Line 200 is past the active screen and must stay silent
        io_write(asic_bus_pkg::port_lineint, 8'd200);
        bus_idle();
        @(negedge vsync_pal);
        repeat (4) io_read(asic_bus_pkg::port_status);
        bus_idle();
        repeat (3200) @(posedge clk);
        finish_run(0);
    end

endmodule

// ==== vlog.f ====
asic_video_pkg.sv
asic_bus_pkg.sv
io_port_regs.sv
raster_timing.sv
cpu_memory_map.sv
cpu_read_mux.sv
asic_top.sv
asic_properties.sv
tb_asic.sv

// ==== Makefile ====
# Verilator build and run for the gate array testbench

TOP        ?= tb_asic
SEED       ?= 90
LOG        ?= sim.log
BUILD_DIR  ?= obj_dir
FILELIST   ?= vlog.f
VERILATOR  ?= verilator
VFLAGS     ?= --assert --timescale 1ns/1ps -j 0
LINT_FLAGS ?= --assert --timing --timescale 1ns/1ps
SIM_ARGS   ?= +verilator+seed+$(SEED) +verilator+error+limit+100000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -qx "Test passed" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
